// ==== bench/ooo_core_tb.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module ooo_core_tb;

	localparam int NUM_INSTR  = 64;
	localparam int QDEPTH     = `CORE_QUEUE_DEPTH;
	localparam int MAX_CYCLES = 40 * NUM_INSTR;
	// first part of the program is directed, the rest random
	localparam int NUM_DIRECTED = 10;

	logic clock;
	logic reset;
	logic instr_valid;
	isa_pkg::instr_word_t instr;
	logic instr_credit;
	ooo_pkg::commit_t commit;

	// program and architectural reference state
	isa_pkg::instr_word_t prog [NUM_INSTR];
	logic [`CORE_XLEN-1:0] model_regs [`CORE_NUM_REGS];
	isa_pkg::instr_word_t head_word;
	logic [`CORE_XLEN-1:0] exp_value;
	logic exp_writes;
	logic exp_illegal;

	// fetch side bookkeeping
	int seed;
	int errors;
	int cycles;
	int send_idx;
	int commit_idx;
	int credits;
	int credits_back;
	int roll;
	logic started;
	logic send_now;

	ooo_core uut (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_credit(instr_credit),
		.commit(commit)
	);

	always #50 clock = ~clock;

	// pack one instruction word
	function automatic isa_pkg::instr_word_t make_word(
		input logic [3:0] op,
		input int rd,
		input int rs1,
		input int rs2,
		input logic [15:0] imm
	);
		isa_pkg::instr_word_t w;
		w.opcode = op;
		w.rd = rd[3:0];
		w.rs1 = rs1[3:0];
		w.rs2 = rs2[3:0];
		w.imm16 = imm;
		return w;
	endfunction

	// architectural result of one legal word
	function automatic logic [`CORE_XLEN-1:0] ref_result(
		input isa_pkg::instr_word_t w,
		input logic [`CORE_XLEN-1:0] a,
		input logic [`CORE_XLEN-1:0] b
	);
		logic [`CORE_XLEN-1:0] imm;
		imm = {{(`CORE_XLEN - 16){w.imm16[15]}}, w.imm16};
		case (w.opcode)
			isa_pkg::OP_ADD:  return a + b;
			isa_pkg::OP_SUB:  return a - b;
			isa_pkg::OP_AND:  return a & b;
			isa_pkg::OP_OR:   return a | b;
			isa_pkg::OP_XOR:  return a ^ b;
			isa_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
			isa_pkg::OP_ADDI: return a + imm;
			isa_pkg::OP_MUL:  return a * b;
			default:          return '0;
		endcase
	endfunction

	task automatic build_program();
		int r;
		logic [3:0] op;
		// dependent MUL/ALU chain
		prog[0] = make_word(isa_pkg::OP_ADDI, 1, 0, 0, 16'd3);
		prog[1] = make_word(isa_pkg::OP_MUL, 2, 1, 1, 16'd0);
		prog[2] = make_word(isa_pkg::OP_ADD, 3, 2, 1, 16'd0);
		prog[3] = make_word(isa_pkg::OP_MUL, 4, 3, 2, 16'd0);
		prog[4] = make_word(isa_pkg::OP_SUB, 5, 4, 3, 16'd0);
		// r0 write, then illegal aimed at r1, then reads of both
		prog[5] = make_word(isa_pkg::OP_ADDI, 0, 5, 0, 16'd7);
		prog[6] = make_word(4'hb, 1, 2, 3, 16'h1234);
		prog[7] = make_word(isa_pkg::OP_ADD, 6, 1, 0, 16'd0);
		prog[8] = make_word(isa_pkg::OP_ADDI, 7, 0, 0, 16'hffff);
		prog[9] = make_word(isa_pkg::OP_SLT, 8, 7, 1, 16'd0);
		for (int i = NUM_DIRECTED; i < NUM_INSTR; i++) begin
			r = $unsigned($random(seed)) % 16;
			// MUL and ADDI weighted up, a few illegal codes
			if (r < 8) begin
				op = r[3:0];
			end else if (r < 12) begin
				op = isa_pkg::OP_MUL;
			end else if (r < 14) begin
				op = isa_pkg::OP_ADDI;
			end else begin
				op = 4'h8 | 4'($unsigned($random(seed)) % 8);
			end
			// small register set keeps chains dense
			prog[i] = make_word(op, $unsigned($random(seed)) % 8,
				$unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8,
				16'($random(seed)));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// expected commit for the next program-order word
	always_comb begin
		head_word = prog[(commit_idx < NUM_INSTR) ? commit_idx : 0];
		exp_illegal = head_word.opcode[3];
		exp_writes = !exp_illegal && (head_word.rd != 0);
		exp_value = ref_result(head_word, model_regs[head_word.rs1], model_regs[head_word.rs2]);
	end

	always @(posedge clock) begin
		if (reset) begin
			commit_idx <= 0;
			for (int r = 0; r < `CORE_NUM_REGS; r++) begin
				model_regs[r] <= '0;
			end
		end else if (commit.valid) begin
			if (exp_writes) begin
				model_regs[head_word.rd] <= exp_value;
			end
			commit_idx <= commit_idx + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// fetch source
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			instr_valid <= 1'b0;
			send_idx <= 0;
			credits <= QDEPTH;
			credits_back <= 0;
		end else begin
			roll = $unsigned($random(seed)) % 4;
			// random gaps in the first half, then a flat-out burst
			send_now = started && (send_idx < NUM_INSTR) && (credits > 0)
				&& ((send_idx >= NUM_INSTR / 2) || (roll != 0));
			instr_valid <= send_now;
			if (send_now) begin
				instr <= prog[send_idx];
			end
			send_idx <= send_idx + int'(send_now);
			credits <= credits - int'(send_now) + int'(instr_credit);
			credits_back <= credits_back + int'(instr_credit);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (reset)
		commit.valid && !exp_illegal |-> commit.value == exp_value)
		else begin
			errors++;
			$display("mismatch commit.value: got %h expected %h",
				$sampled(commit.value), $sampled(exp_value));
		end

	assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> commit.rd == head_word.rd)
		else begin
			errors++;
			$display("mismatch commit.rd: got %h expected %h",
				$sampled(commit.rd), $sampled(head_word.rd));
		end

	assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> commit.writes_rd == exp_writes)
		else begin
			errors++;
			$display("mismatch commit.writes_rd: got %h expected %h",
				$sampled(commit.writes_rd), $sampled(exp_writes));
		end

	assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> commit.illegal == exp_illegal)
		else begin
			errors++;
			$display("mismatch commit.illegal: got %h expected %h",
				$sampled(commit.illegal), $sampled(exp_illegal));
		end

	assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> commit.seq == commit_idx[15:0])
		else begin
			errors++;
			$display("mismatch commit.seq: got %h expected %h",
				$sampled(commit.seq), $sampled(commit_idx[15:0]));
		end

	// a commit must belong to a word already sent
	assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> commit_idx < send_idx)
		else begin
			errors++;
			$display("commit seen with no instruction outstanding");
		end

	assert property (@(posedge clock) disable iff (reset)
		credits >= 0 && credits <= QDEPTH)
		else begin
			errors++;
			$display("source credit count left its range, now %0d", $sampled(credits));
		end

	assert property (@(posedge clock) disable iff (reset) credits_back <= send_idx)
		else begin
			errors++;
			$display("core returned more credits than words were sent");
		end

	// quiet outputs between reset and first word
	assert property (@(posedge clock) disable iff (reset)
		!started |-> !instr_credit && !commit.valid)
		else begin
			errors++;
			$display("credit or commit active before any stimulus");
		end

	//////////////////////////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: %0d of %0d instructions committed after %0d cycles",
				commit_idx, NUM_INSTR, cycles);
			$display("errors: %0d, sent: %0d, committed: %0d", errors, send_idx, commit_idx);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		seed = 32'h97cc;
		errors = 0;
		cycles = 0;
		clock = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		started = 1'b0;
		build_program();
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		// a few idle cycles to watch the outputs stay low
		repeat (5) @(posedge clock);
		started <= 1'b1;
		wait (commit_idx >= NUM_INSTR);
		repeat (4) @(posedge clock);
		if (send_idx != NUM_INSTR || commit_idx != NUM_INSTR) begin
			errors++;
			$display("sent and committed instruction counts do not match the program");
		end
		if (credits != QDEPTH) begin
			errors++;
			$display("mismatch credits: got %h expected %h", credits, QDEPTH);
		end
		$display("errors: %0d, sent: %0d, committed: %0d", errors, send_idx, commit_idx);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// width of every register, operand and result
`define CORE_XLEN 32

// architectural registers, r0 always reads zero
`define CORE_NUM_REGS 16

// reorder entries, one tag per entry
`define CORE_ROB_DEPTH 8

// slots in each credit queue
// a sender starts with this many credits
`define CORE_QUEUE_DEPTH 4

// multiplier stages from issue to result bus
`define CORE_MUL_LATENCY 3

`endif

// ==== hdl/credit_queue.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module credit_queue #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output logic     head_valid,
	output payload_t head_data,
	output logic     credit
);

	localparam int DEPTH   = `CORE_QUEUE_DEPTH;
	localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [COUNT_W-1:0] count;
	logic do_pop;

	assign head_valid = (count != '0);
	assign head_data = mem[rd_ptr];
	// pop on an empty ring is ignored
	assign do_pop = pop && head_valid;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + COUNT_W'(push) - COUNT_W'(do_pop);
			// one credit back per released slot
			credit <= do_pop;
		end
	end

	// sender pushed without a credit in hand
	assert property (@(posedge clock) disable iff (reset) push |-> count != COUNT_W'(DEPTH))
		else $error("credit_queue: push into a full queue");

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 in_valid,
	input  isa_pkg::instr_word_t in_word,
	output logic                 in_pop,
	output logic                 out_push,
	output isa_pkg::decoded_t    out_pkt,
	input  logic                 out_credit
);

	localparam int QDEPTH = `CORE_QUEUE_DEPTH;
	localparam int CRED_W = $clog2(QDEPTH + 1);

	logic [CRED_W-1:0] credits;
	logic [15:0] seq;
	logic legal;
	isa_pkg::decoded_t dec;

	// only take a word when the decoded queue has room for it
	assign in_pop = in_valid && (credits != '0);

	//////////////////////////////////////////////////////////////////////
	// crack the word
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// defined codes all live below 8
		legal = !in_word.opcode[3];
		dec.opcode = legal ? isa_pkg::opcode_e'(in_word.opcode) : isa_pkg::OP_ADD;
		dec.rd = in_word.rd;
		dec.rs1 = in_word.rs1;
		dec.rs2 = in_word.rs2;
		// sign extend imm16
		dec.imm = {{(`CORE_XLEN - 16){in_word.imm16[15]}}, in_word.imm16};
		dec.use_imm = legal && (dec.opcode == isa_pkg::OP_ADDI);
		dec.uses_rs2 = legal && (dec.opcode != isa_pkg::OP_ADDI);
		// r0 stays zero, illegal writes nothing
		dec.writes_rd = legal && (in_word.rd != '0);
		dec.illegal = !legal;
		dec.is_mul = legal && (dec.opcode == isa_pkg::OP_MUL);
		dec.seq = seq;
	end

	//////////////////////////////////////////////////////////////////////
	// output register and credit count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			out_push <= 1'b0;
			credits <= CRED_W'(QDEPTH);
			seq <= '0;
		end else begin
			out_push <= in_pop;
			if (in_pop) begin
				out_pkt <= dec;
				seq <= seq + 1'b1;
			end
			credits <= credits - CRED_W'(in_pop) + CRED_W'(out_credit);
		end
	end

	// queue returned more credits than it ever had slots
	assert property (@(posedge clock) disable iff (reset) credits <= CRED_W'(QDEPTH))
		else $error("decode_stage: credit count above queue depth");

endmodule

// ==== hdl/exec_units.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module exec_units (
	input  logic                clock,
	input  logic                reset,
	input  ooo_pkg::issue_pkt_t issue,
	output ooo_pkg::result_t    result
);

	localparam int MUL_LAT = `CORE_MUL_LATENCY;

	ooo_pkg::result_t alu_q;
	ooo_pkg::result_t mul_pipe [MUL_LAT];
	logic [`CORE_XLEN-1:0] alu_value;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (issue.opcode)
			isa_pkg::OP_ADD,
			isa_pkg::OP_ADDI: alu_value = issue.a + issue.b;
			isa_pkg::OP_SUB:  alu_value = issue.a - issue.b;
			isa_pkg::OP_AND:  alu_value = issue.a & issue.b;
			isa_pkg::OP_OR:   alu_value = issue.a | issue.b;
			isa_pkg::OP_XOR:  alu_value = issue.a ^ issue.b;
			// signed compare
			isa_pkg::OP_SLT: begin
				alu_value = {{(`CORE_XLEN - 1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
			end
			default:          alu_value = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// ALU stage and multiplier pipe
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_q.valid <= 1'b0;
			for (int s = 0; s < MUL_LAT; s++) begin
				mul_pipe[s].valid <= 1'b0;
			end
		end else begin
			alu_q.valid <= issue.valid && !issue.is_mul;
			alu_q.tag <= issue.tag;
			alu_q.value <= alu_value;
			// product in the first stage, later stages just carry it
			mul_pipe[0].valid <= issue.valid && issue.is_mul;
			mul_pipe[0].tag <= issue.tag;
			// low word of the product
			mul_pipe[0].value <= issue.a * issue.b;
			for (int s = 1; s < MUL_LAT; s++) begin
				mul_pipe[s] <= mul_pipe[s-1];
			end
		end
	end

	// idle bus shows alu_q with valid low
	assign result = mul_pipe[MUL_LAT-1].valid ? mul_pipe[MUL_LAT-1] : alu_q;

	// issue spacing must keep both paths off the bus together
	assert property (@(posedge clock) disable iff (reset)
		!(alu_q.valid && mul_pipe[MUL_LAT-1].valid))
		else $error("exec_units: ALU and MUL results collide on the bus");

endmodule

// ==== hdl/isa_pkg.sv ====
`include "core_params.svh"

package isa_pkg;

	// register index
	typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

	// defined operations, codes 8..15 are illegal
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SLT  = 4'h5,
		OP_ADDI = 4'h6,
		OP_MUL  = 4'h7
	} opcode_e;

	// raw word as it arrives from fetch
	// opcode kept as plain bits so undefined codes survive
	typedef struct packed {
		logic [3:0]  opcode;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [15:0] imm16;
	} instr_word_t;

	// cracked instruction handed from decode to issue
	typedef struct packed {
		opcode_e               opcode;
		reg_idx_t              rd;
		reg_idx_t              rs1;
		reg_idx_t              rs2;
		logic [`CORE_XLEN-1:0] imm;
		logic                  use_imm;
		logic                  uses_rs2;
		logic                  writes_rd;
		logic                  illegal;
		logic                  is_mul;
		logic [15:0]           seq;
	} decoded_t;

endpackage

// ==== hdl/issue_window.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module issue_window (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        dec_valid,
	input  isa_pkg::decoded_t           dec_pkt,
	output logic                        dec_pop,
	input  logic                        rob_has_room,
	output logic                        alloc,
	input  ooo_pkg::rob_tag_t           alloc_tag,
	output isa_pkg::reg_idx_t           alloc_rd,
	output logic                        alloc_writes_rd,
	output logic                        alloc_illegal,
	output ooo_pkg::rob_tag_t [1:0]     fwd_tag,
	input  ooo_pkg::operand_t [1:0]     fwd_operand,
	input  ooo_pkg::result_t            result,
	input  ooo_pkg::commit_t            commit,
	output ooo_pkg::issue_pkt_t         issue
);

	localparam int NUM_REGS = `CORE_NUM_REGS;
	localparam int MUL_LAT  = `CORE_MUL_LATENCY;

	// architectural state and rename map
	logic [`CORE_XLEN-1:0] regs [NUM_REGS];
	logic [NUM_REGS-1:0] map_valid;
	ooo_pkg::rob_tag_t map_tag [NUM_REGS];
	// tag of the next entry to retire
	ooo_pkg::rob_tag_t commit_tag;

	// single hold slot
	logic slot_valid;
	isa_pkg::opcode_e slot_op;
	logic slot_mul;
	ooo_pkg::rob_tag_t slot_tag;
	ooo_pkg::operand_t slot_a;
	ooo_pkg::operand_t slot_b;

	ooo_pkg::operand_t src_a;
	ooo_pkg::operand_t src_b;
	logic slot_fire;
	logic bus_busy;
	// bit k set when a MUL fired k+1 cycles ago
	logic [MUL_LAT-2:0] mul_fired;
	logic [15:0] next_seq;

	// regfile when not renamed, else rob, else the bus this cycle
	function automatic ooo_pkg::operand_t source_operand(
		input isa_pkg::reg_idx_t idx,
		input ooo_pkg::operand_t fwd
	);
		ooo_pkg::operand_t op;
		op.tag = map_tag[idx];
		op.ready = 1'b1;
		op.value = regs[idx];
		if (map_valid[idx]) begin
			op.ready = fwd.ready;
			op.value = fwd.value;
			if (!fwd.ready && result.valid && result.tag == map_tag[idx]) begin
				op.ready = 1'b1;
				op.value = result.value;
			end
		end
		return op;
	endfunction

	// waiting operand snoops the result bus
	function automatic ooo_pkg::operand_t capture(input ooo_pkg::operand_t op);
		ooo_pkg::operand_t nxt;
		nxt = op;
		if (!op.ready && result.valid && result.tag == op.tag) begin
			nxt.ready = 1'b1;
			nxt.value = result.value;
		end
		return nxt;
	endfunction

	assign fwd_tag[0] = map_tag[dec_pkt.rs1];
	assign fwd_tag[1] = map_tag[dec_pkt.rs2];

	// an ALU fired now would land on the bus with that MUL
	assign bus_busy = !slot_mul && mul_fired[MUL_LAT-2];
	assign slot_fire = slot_valid && slot_a.ready && slot_b.ready && !bus_busy;

	// slot frees up in the same cycle it fires
	assign alloc = dec_valid && rob_has_room && (!slot_valid || slot_fire);
	assign dec_pop = alloc;
	assign alloc_rd = dec_pkt.rd;
	assign alloc_writes_rd = dec_pkt.writes_rd;
	assign alloc_illegal = dec_pkt.illegal;

	always_comb begin
		src_a = source_operand(dec_pkt.rs1, fwd_operand[0]);
		src_b = source_operand(dec_pkt.rs2, fwd_operand[1]);
		if (!dec_pkt.uses_rs2) begin
			src_b.ready = 1'b1;
			src_b.value = dec_pkt.use_imm ? dec_pkt.imm : '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// map, register file, slot and issue register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
				map_tag[r] <= '0;
			end
			map_valid <= '0;
			commit_tag <= '0;
			slot_valid <= 1'b0;
			mul_fired <= '0;
			issue.valid <= 1'b0;
			next_seq <= '0;
		end else begin
			// retire first so a rename in the same cycle wins
			if (commit.valid) begin
				commit_tag <= commit_tag + 1'b1;
				if (commit.writes_rd) begin
					regs[commit.rd] <= commit.value;
					if (map_valid[commit.rd] && map_tag[commit.rd] == commit_tag) begin
						map_valid[commit.rd] <= 1'b0;
					end
				end
			end
			if (alloc) begin
				next_seq <= next_seq + 1'b1;
				if (dec_pkt.writes_rd) begin
					map_valid[dec_pkt.rd] <= 1'b1;
					map_tag[dec_pkt.rd] <= alloc_tag;
				end
			end

			// illegal entries never occupy the slot
			if (alloc && !dec_pkt.illegal) begin
				slot_valid <= 1'b1;
				slot_op <= dec_pkt.opcode;
				slot_mul <= dec_pkt.is_mul;
				slot_tag <= alloc_tag;
				slot_a <= src_a;
				slot_b <= src_b;
			end else begin
				if (slot_fire) begin
					slot_valid <= 1'b0;
				end
				slot_a <= capture(slot_a);
				slot_b <= capture(slot_b);
			end

			issue.valid <= slot_fire;
			issue.opcode <= slot_op;
			issue.a <= slot_a.value;
			issue.b <= slot_b.value;
			issue.tag <= slot_tag;
			issue.is_mul <= slot_mul;
			mul_fired <= (mul_fired << 1) | (MUL_LAT - 1)'(slot_fire && slot_mul);
		end
	end

	// no decoded word lost or reordered on the way from decode
	assert property (@(posedge clock) disable iff (reset) alloc |-> dec_pkt.seq == next_seq)
		else $error("issue_window: sequence gap at allocation");

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 instr_valid,
	input  isa_pkg::instr_word_t instr,
	output logic                 instr_credit,
	output ooo_pkg::commit_t     commit
);

	// fetch queue to decode
	logic fetch_valid;
	logic fetch_pop;
	isa_pkg::instr_word_t fetch_word;

	// decode to decoded queue
	logic dec_push;
	logic dec_credit;
	isa_pkg::decoded_t dec_push_pkt;

	// decoded queue to issue
	logic dec_valid;
	logic dec_pop;
	isa_pkg::decoded_t dec_pkt;

	// issue and reorder buffer handshake
	logic rob_has_room;
	logic alloc;
	ooo_pkg::rob_tag_t alloc_tag;
	isa_pkg::reg_idx_t alloc_rd;
	logic alloc_writes_rd;
	logic alloc_illegal;
	ooo_pkg::rob_tag_t [1:0] fwd_tag;
	ooo_pkg::operand_t [1:0] fwd_operand;

	// execute
	ooo_pkg::issue_pkt_t issue;
	ooo_pkg::result_t result;

	//////////////////////////////////////////////////////////////////////
	// front end
	//////////////////////////////////////////////////////////////////////

	credit_queue #(.payload_t(isa_pkg::instr_word_t)) fetch_q (
		.clock(clock),
		.reset(reset),
		.push(instr_valid),
		.push_data(instr),
		.pop(fetch_pop),
		.head_valid(fetch_valid),
		.head_data(fetch_word),
		.credit(instr_credit)
	);

	decode_stage decode (
		.clock(clock),
		.reset(reset),
		.in_valid(fetch_valid),
		.in_word(fetch_word),
		.in_pop(fetch_pop),
		.out_push(dec_push),
		.out_pkt(dec_push_pkt),
		.out_credit(dec_credit)
	);

	credit_queue #(.payload_t(isa_pkg::decoded_t)) dec_q (
		.clock(clock),
		.reset(reset),
		.push(dec_push),
		.push_data(dec_push_pkt),
		.pop(dec_pop),
		.head_valid(dec_valid),
		.head_data(dec_pkt),
		.credit(dec_credit)
	);

	//////////////////////////////////////////////////////////////////////
	// back end
	//////////////////////////////////////////////////////////////////////

	issue_window issue_win (
		.clock(clock),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_pkt(dec_pkt),
		.dec_pop(dec_pop),
		.rob_has_room(rob_has_room),
		.alloc(alloc),
		.alloc_tag(alloc_tag),
		.alloc_rd(alloc_rd),
		.alloc_writes_rd(alloc_writes_rd),
		.alloc_illegal(alloc_illegal),
		.fwd_tag(fwd_tag),
		.fwd_operand(fwd_operand),
		.result(result),
		.commit(commit),
		.issue(issue)
	);

	exec_units exec (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.result(result)
	);

	reorder_buffer rob (
		.clock(clock),
		.reset(reset),
		.alloc(alloc),
		.alloc_rd(alloc_rd),
		.alloc_writes_rd(alloc_writes_rd),
		.alloc_illegal(alloc_illegal),
		.rob_has_room(rob_has_room),
		.alloc_tag(alloc_tag),
		.fwd_tag(fwd_tag),
		.fwd_operand(fwd_operand),
		.result(result),
		.commit(commit)
	);

endmodule

// ==== hdl/ooo_pkg.sv ====
`include "core_params.svh"

package ooo_pkg;

	// reorder buffer index, doubles as rename tag
	typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_tag_t;

	// source operand
	// value is only meaningful once ready is set
	// while waiting, tag names the producing entry
	typedef struct packed {
		logic                  ready;
		rob_tag_t              tag;
		logic [`CORE_XLEN-1:0] value;
	} operand_t;

	// one instruction leaving the issue window
	typedef struct packed {
		logic                  valid;
		isa_pkg::opcode_e      opcode;
		logic [`CORE_XLEN-1:0] a;
		logic [`CORE_XLEN-1:0] b;
		rob_tag_t              tag;
		logic                  is_mul;
	} issue_pkt_t;

	// shared result bus, one entry per cycle
	typedef struct packed {
		logic                  valid;
		rob_tag_t              tag;
		logic [`CORE_XLEN-1:0] value;
	} result_t;

	// retire report, also drives register file write
	typedef struct packed {
		logic                  valid;
		isa_pkg::reg_idx_t     rd;
		logic [`CORE_XLEN-1:0] value;
		logic                  writes_rd;
		logic                  illegal;
		logic [15:0]           seq;
	} commit_t;

endpackage

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module reorder_buffer (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    alloc,
	input  isa_pkg::reg_idx_t       alloc_rd,
	input  logic                    alloc_writes_rd,
	input  logic                    alloc_illegal,
	output logic                    rob_has_room,
	output ooo_pkg::rob_tag_t       alloc_tag,
	input  ooo_pkg::rob_tag_t [1:0] fwd_tag,
	output ooo_pkg::operand_t [1:0] fwd_operand,
	input  ooo_pkg::result_t        result,
	output ooo_pkg::commit_t        commit
);

	localparam int DEPTH = `CORE_ROB_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// per entry control
	logic [DEPTH-1:0] ent_valid;
	logic [DEPTH-1:0] ent_ready;
	// per entry payload
	isa_pkg::reg_idx_t ent_rd [DEPTH];
	logic [DEPTH-1:0] ent_writes;
	logic [DEPTH-1:0] ent_illegal;
	logic [`CORE_XLEN-1:0] ent_value [DEPTH];

	// head and tail wrap on their own, depth is a power of two
	ooo_pkg::rob_tag_t head;
	ooo_pkg::rob_tag_t tail;
	logic [CNT_W-1:0] count;
	logic [15:0] commit_seq;
	logic retire;

	// full means full, a retire this cycle does not count
	assign rob_has_room = (count != CNT_W'(DEPTH));
	assign alloc_tag = tail;
	assign retire = ent_valid[head] && ent_ready[head];

	//////////////////////////////////////////////////////////////////////
	// retire port and operand forwarding
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		commit.valid = retire;
		commit.rd = ent_rd[head];
		commit.value = ent_value[head];
		commit.writes_rd = ent_writes[head];
		commit.illegal = ent_illegal[head];
		commit.seq = commit_seq;
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			fwd_operand[i].ready = ent_valid[fwd_tag[i]] && ent_ready[fwd_tag[i]];
			fwd_operand[i].tag = fwd_tag[i];
			fwd_operand[i].value = ent_value[fwd_tag[i]];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// entry state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			ent_valid <= '0;
			ent_ready <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			commit_seq <= '0;
		end else begin
			if (retire) begin
				ent_valid[head] <= 1'b0;
				head <= head + 1'b1;
				commit_seq <= commit_seq + 1'b1;
			end
			if (result.valid) begin
				ent_ready[result.tag] <= 1'b1;
			end
			// illegal has nothing to wait for
			if (alloc) begin
				ent_valid[tail] <= 1'b1;
				ent_ready[tail] <= alloc_illegal;
				tail <= tail + 1'b1;
			end
			count <= count + CNT_W'(alloc) - CNT_W'(retire);
		end
	end

	always_ff @(posedge clock) begin
		if (alloc) begin
			ent_rd[tail] <= alloc_rd;
			ent_writes[tail] <= alloc_writes_rd;
			ent_illegal[tail] <= alloc_illegal;
			ent_value[tail] <= '0;
		end
		if (result.valid) begin
			ent_value[result.tag] <= result.value;
		end
	end

	// execute finished something that was never allocated
	assert property (@(posedge clock) disable iff (reset) result.valid |-> ent_valid[result.tag])
		else $error("reorder_buffer: result for empty entry %0h", result.tag);

endmodule

// ==== src.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/ooo_pkg.sv
hdl/credit_queue.sv
hdl/decode_stage.sv
hdl/issue_window.sv
hdl/exec_units.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
bench/ooo_core_tb.sv
